//--- rtl/decode_pkg.sv
// decode package: instruction views, control encodings and stage structs
package decode_pkg;

  // register-format view of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // immediate view, bits 31..7 as one field
  typedef struct packed {
    logic [24:0] imm;
    logic [6:0]  opcode;
  } inst_imm_t;

  typedef union packed {
    inst_r_t   rtype;
    inst_imm_t itype;
  } inst_u;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_IMM
  } alu_op_e;

  typedef enum logic {SRC2_REG, SRC2_IMM} src2_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_REL, PC_JALR} pc_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

  typedef struct packed {
    logic [31:0] pc;
    inst_u       inst;
  } fetch_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        src1_is_pc;
    src2_sel_e   src2_sel;
    pc_sel_e     pc_sel;
    logic        is_branch;
    logic [2:0]  funct3;
    logic        mem_read;
    logic        mem_write;
    logic [3:0]  wmask;
    logic        load_signed;
    logic        reg_write;
    wb_sel_e     wb_sel;
    logic [4:0]  rd;
  } ctrl_t;

  typedef struct packed {
    logic        pending;
    logic        ready;
    logic [4:0]  rd;
    logic [31:0] data;
  } ex_fwd_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_fwd_t;

  typedef struct packed {
    fetch_t      fetch;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] store_data;
    logic [31:0] next_pc;
  } issue_t;

endpackage

//--- rtl/fetch_buffer.sv
// fetch buffer: idle/decode FSM, one-entry skid buffer and current instruction select
`timescale 1ns/10ps

module fetch_buffer
  import decode_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  fetch_t fetch_i,
  input  logic   fetch_valid_i,
  input  logic   issue_en_i,
  input  logic   issue_done_i,
  output logic   fetch_ready_o,
  output logic   decoding_o,
  output fetch_t cur_o
);

  typedef enum logic {IDLE, DECODE} state_e;

  state_e state;
  state_e next_state;
  fetch_t buf_q;
  fetch_t held_q;
  logic   buf_valid;
  logic   buf_load;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (fetch_valid_i || buf_valid) begin
          next_state = DECODE;
        end
      end
      DECODE: begin
        if (issue_done_i) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // arrival while busy goes to the buffer
  assign buf_load = (state == DECODE) && fetch_valid_i && !buf_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_valid <= 1'b0;
    end else if (buf_load) begin
      buf_valid <= 1'b1;
    end else if (state == IDLE) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (buf_load) begin
      buf_q <= fetch_i;
    end
  end

  // held copy only matters when the entering instruction stalls
  always_ff @(posedge clk) begin
    if (state == IDLE && !issue_en_i) begin
      held_q <= cur_o;
    end
  end

  always_comb begin
    if (state == DECODE && next_state == DECODE) begin
      cur_o = held_q;
    end else if (buf_valid) begin
      cur_o = buf_q;
    end else begin
      cur_o = fetch_i;
    end
  end

  assign decoding_o    = (next_state == DECODE);
  assign fetch_ready_o = !buf_valid;

endmodule

//--- rtl/inst_decoder.sv
// instruction decoder: RV32I opcode/funct decode into controls and immediate
`timescale 1ns/10ps

module inst_decoder
  import decode_pkg::*;
(
  input  inst_u       inst_i,
  output ctrl_t       ctrl_o,
  output logic [31:0] imm_o
);

  logic [24:0] ib;
  logic [31:0] imm_i_fmt;
  logic [31:0] imm_s_fmt;
  logic [31:0] imm_b_fmt;
  logic [31:0] imm_u_fmt;
  logic [31:0] imm_j_fmt;

  // sub only exists in register form, shifts use bit 30 in both
  function automatic alu_op_e alu_map(
    input logic [2:0] f3,
    input logic       f7_alt,
    input logic       is_reg
  );
    case (f3)
      3'b000:  return (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ib[k] is instruction bit k+7
  assign ib = inst_i.itype.imm;

  assign imm_i_fmt = {{20{ib[24]}}, ib[24:13]};
  assign imm_s_fmt = {{20{ib[24]}}, ib[24:18], ib[4:0]};
  assign imm_b_fmt = {{19{ib[24]}}, ib[24], ib[0], ib[23:18], ib[4:1], 1'b0};
  assign imm_u_fmt = {ib[24:5], 12'b0};
  assign imm_j_fmt = {{11{ib[24]}}, ib[24], ib[12:5], ib[13], ib[23:14], 1'b0};

  always_comb begin
    ctrl_o.alu_op      = ALU_ADD;
    ctrl_o.src1_is_pc  = 1'b0;
    ctrl_o.src2_sel    = SRC2_REG;
    ctrl_o.pc_sel      = PC_SEQ;
    ctrl_o.is_branch   = 1'b0;
    ctrl_o.funct3      = inst_i.rtype.funct3;
    ctrl_o.mem_read    = 1'b0;
    ctrl_o.mem_write   = 1'b0;
    ctrl_o.wmask       = 4'b0000;
    ctrl_o.load_signed = 1'b0;
    ctrl_o.reg_write   = 1'b0;
    ctrl_o.wb_sel      = WB_ALU;
    ctrl_o.rd          = inst_i.rtype.rd;
    imm_o              = 32'd0;

    case (inst_i.rtype.opcode)
      OP_LUI: begin
        ctrl_o.alu_op    = ALU_IMM;
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u_fmt;
      end
      OP_AUIPC: begin
        ctrl_o.src1_is_pc = 1'b1;
        ctrl_o.src2_sel   = SRC2_IMM;
        ctrl_o.reg_write  = 1'b1;
        imm_o             = imm_u_fmt;
      end
      OP_JAL: begin
        ctrl_o.src1_is_pc = 1'b1;
        ctrl_o.src2_sel   = SRC2_IMM;
        ctrl_o.pc_sel     = PC_REL;
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.wb_sel     = WB_PC4;
        imm_o             = imm_j_fmt;
      end
      OP_JALR: begin
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.pc_sel    = PC_JALR;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = WB_PC4;
        imm_o            = imm_i_fmt;
      end
      OP_BRANCH: begin
        ctrl_o.alu_op    = ALU_SUB;
        ctrl_o.pc_sel    = PC_REL;
        ctrl_o.is_branch = 1'b1;
        imm_o            = imm_b_fmt;
      end
      OP_LOAD: begin
        ctrl_o.src2_sel    = SRC2_IMM;
        ctrl_o.mem_read    = 1'b1;
        ctrl_o.load_signed = !inst_i.rtype.funct3[2];
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.wb_sel      = WB_LOAD;
        imm_o              = imm_i_fmt;
      end
      OP_STORE: begin
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.mem_write = 1'b1;
        case (inst_i.rtype.funct3[1:0])
          2'b00:   ctrl_o.wmask = 4'b0001;
          2'b01:   ctrl_o.wmask = 4'b0011;
          default: ctrl_o.wmask = 4'b1111;
        endcase
        imm_o = imm_s_fmt;
      end
      OP_IMM: begin
        ctrl_o.alu_op    = alu_map(inst_i.rtype.funct3, inst_i.rtype.funct7[5], 1'b0);
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_i_fmt;
      end
      OP_REG: begin
        ctrl_o.alu_op    = alu_map(inst_i.rtype.funct3, inst_i.rtype.funct7[5], 1'b1);
        ctrl_o.reg_write = 1'b1;
      end
      // unknown opcode stays a no-write add
      default: ;
    endcase
  end

endmodule

//--- rtl/operand_forward.sv
// operand forwarding: hazard stall, execute/writeback bypass and source select
`timescale 1ns/10ps

module operand_forward
  import decode_pkg::*;
(
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  ctrl_t       ctrl_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] imm_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  input  ex_fwd_t     ex_fwd_i,
  input  wb_fwd_t     wb_fwd_i,
  output logic [31:0] src1_o,
  output logic [31:0] src2_o,
  output logic [31:0] store_data_o,
  output logic        stall_o
);

  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        rs1_hit;
  logic        rs2_hit;

  // newest value wins, x0 never forwarded
  function automatic logic [31:0] fwd_value(
    input logic [4:0]  idx,
    input logic [31:0] rf_val,
    input ex_fwd_t     ex,
    input wb_fwd_t     wb
  );
    if (idx == 5'd0) begin
      return rf_val;
    end else if (ex.ready && ex.rd == idx) begin
      return ex.data;
    end else if (wb.valid && wb.rd == idx) begin
      return wb.data;
    end
    return rf_val;
  endfunction

  assign rs1_val = fwd_value(rs1_i, rs1_data_i, ex_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_value(rs2_i, rs2_data_i, ex_fwd_i, wb_fwd_i);

  // execute still computing a needed register
  assign rs1_hit = (rs1_i != 5'd0) && (ex_fwd_i.rd == rs1_i);
  assign rs2_hit = (rs2_i != 5'd0) && (ex_fwd_i.rd == rs2_i);
  assign stall_o = ex_fwd_i.pending && (rs1_hit || rs2_hit);

  assign src1_o       = ctrl_i.src1_is_pc ? pc_i : rs1_val;
  assign src2_o       = (ctrl_i.src2_sel == SRC2_IMM) ? imm_i : rs2_val;
  assign store_data_o = rs2_val;

endmodule

//--- rtl/branch_unit.sv
// branch unit: branch condition evaluation and next pc selection
`timescale 1ns/10ps

module branch_unit
  import decode_pkg::*;
(
  input  ctrl_t       ctrl_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] imm_i,
  input  logic [31:0] src1_i,
  input  logic [31:0] src2_i,
  output logic [31:0] next_pc_o
);

  logic        cond;
  logic        taken;
  logic [31:0] pc_plus4;

  always_comb begin
    case (ctrl_i.funct3)
      3'b000:  cond = (src1_i == src2_i);
      3'b001:  cond = (src1_i != src2_i);
      3'b100:  cond = ($signed(src1_i) < $signed(src2_i));
      3'b101:  cond = ($signed(src1_i) >= $signed(src2_i));
      3'b110:  cond = (src1_i < src2_i);
      3'b111:  cond = (src1_i >= src2_i);
      default: cond = 1'b0;
    endcase
  end

  // jal is pc-relative and always taken
  assign taken    = !ctrl_i.is_branch || cond;
  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    case (ctrl_i.pc_sel)
      PC_REL:  next_pc_o = taken ? (pc_i + imm_i) : pc_plus4;
      PC_JALR: next_pc_o = (src1_i + imm_i) & ~32'd1;
      default: next_pc_o = pc_plus4;
    endcase
  end

endmodule

//--- rtl/decode_stage_top.sv
// decode stage top: wires the decode blocks and registers the issue toward execute
`timescale 1ns/10ps

module decode_stage_top
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_t      fetch_i,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  output logic [4:0]  rs1_o,
  output logic [4:0]  rs2_o,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  input  ex_fwd_t     ex_fwd_i,
  input  wb_fwd_t     wb_fwd_i,
  input  logic        exec_ready_i,
  output issue_t      issue_o,
  output logic        issue_valid_o
);

  fetch_t      cur;
  ctrl_t       ctrl;
  logic [31:0] imm;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] store_data;
  logic [31:0] next_pc;
  logic        stall;
  logic        decoding;
  logic        issue_en;
  logic        issue_done;
  issue_t      issue_d;

  assign issue_en   = decoding && !issue_valid_o && !stall;
  assign issue_done = issue_valid_o && exec_ready_i;

  assign rs1_o = cur.inst.rtype.rs1;
  assign rs2_o = cur.inst.rtype.rs2;

  fetch_buffer u_fetch_buffer (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_valid_i (fetch_valid_i),
    .issue_en_i    (issue_en),
    .issue_done_i  (issue_done),
    .fetch_ready_o (fetch_ready_o),
    .decoding_o    (decoding),
    .cur_o         (cur)
  );

  inst_decoder u_inst_decoder (
    .inst_i (cur.inst),
    .ctrl_o (ctrl),
    .imm_o  (imm)
  );

  operand_forward u_operand_forward (
    .rs1_i        (rs1_o),
    .rs2_i        (rs2_o),
    .ctrl_i       (ctrl),
    .pc_i         (cur.pc),
    .imm_i        (imm),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .ex_fwd_i     (ex_fwd_i),
    .wb_fwd_i     (wb_fwd_i),
    .src1_o       (src1),
    .src2_o       (src2),
    .store_data_o (store_data),
    .stall_o      (stall)
  );

  branch_unit u_branch_unit (
    .ctrl_i    (ctrl),
    .pc_i      (cur.pc),
    .imm_i     (imm),
    .src1_i    (src1),
    .src2_i    (src2),
    .next_pc_o (next_pc)
  );

  always_comb begin
    issue_d.fetch      = cur;
    issue_d.ctrl       = ctrl;
    issue_d.imm        = imm;
    issue_d.src1       = src1;
    issue_d.src2       = src2;
    issue_d.store_data = store_data;
    issue_d.next_pc    = next_pc;
  end

  // output holds until execute takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_o       <= '0;
      issue_valid_o <= 1'b0;
    end else if (issue_en) begin
      issue_o       <= issue_d;
      issue_valid_o <= 1'b1;
    end else if (issue_done) begin
      issue_valid_o <= 1'b0;
    end
  end

endmodule

//--- testbench/tb_decode_stage.sv
// decode stage testbench: replays the vector file through the DUT and checks each issue
`timescale 1ns/10ps

module tb_decode_stage
  import decode_pkg::*;
;

  localparam int NUM_VECTORS = 23;
  localparam int TIMEOUT     = 50;

  // one line of the vector file
  typedef struct packed {
    logic [7:0]  name;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [7:0]  ex_flags;
    logic [7:0]  ex_rd;
    logic [31:0] ex_data;
    logic [7:0]  wb_valid;
    logic [7:0]  wb_rd;
    logic [31:0] wb_data;
    logic [7:0]  hold;
    logic [7:0]  delay;
    logic [7:0]  alu;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] store_data;
    logic [31:0] next_pc;
  } vector_t;

  logic        clk;
  logic        rst;
  fetch_t      fetch_i;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  logic [4:0]  rs1_o;
  logic [4:0]  rs2_o;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  ex_fwd_t     ex_fwd_i;
  wb_fwd_t     wb_fwd_i;
  logic        exec_ready_i;
  issue_t      issue_o;
  logic        issue_valid_o;

  logic [415:0] vec_mem [0:NUM_VECTORS-1];
  int           errors;
  int           tests_run;
  int           tests_failed;

  decode_stage_top u_decode_stage_top (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_fwd_i      (ex_fwd_i),
    .wb_fwd_i      (wb_fwd_i),
    .exec_ready_i  (exec_ready_i),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", label, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string label, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", label);
    end else begin
      tests_failed++;
      $display("%s: failed", label);
    end
  endtask

  // pending is held only for the hazard window
  task automatic drive_vector(input vector_t v);
    fetch_i          <= {v.pc, v.inst};
    fetch_valid_i    <= 1'b1;
    rs1_data_i       <= v.rs1_data;
    rs2_data_i       <= v.rs2_data;
    ex_fwd_i.pending <= (v.hold != 8'd0);
    ex_fwd_i.ready   <= (v.hold == 8'd0) && v.ex_flags[0];
    ex_fwd_i.rd      <= v.ex_rd[4:0];
    ex_fwd_i.data    <= v.ex_data;
    wb_fwd_i.valid   <= v.wb_valid[0];
    wb_fwd_i.rd      <= v.wb_rd[4:0];
    wb_fwd_i.data    <= v.wb_data;
  endtask

  // register file read indexes come from bits 19:15 and 24:20
  task automatic expect_read_index(input string label, input vector_t v);
    check_value({label, ".rs1_o"}, 32'(v.inst[19:15]), 32'(rs1_o));
    check_value({label, ".rs2_o"}, 32'(v.inst[24:20]), 32'(rs2_o));
  endtask

  task automatic wait_issue(input string label, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      if (issue_valid_o === 1'b1) begin
        seen = 1'b1;
      end
      cycles++;
    end
    if (!seen) begin
      $display("%s: issue_valid_o never rose within %0d cycles", label, TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_issue(input string label, input vector_t v);
    check_value({label, ".pc"}, v.pc, issue_o.fetch.pc);
    check_value({label, ".inst"}, v.inst, issue_o.fetch.inst);
    check_value({label, ".alu_op"}, 32'(v.alu), 32'(issue_o.ctrl.alu_op));
    check_value({label, ".imm"}, v.imm, issue_o.imm);
    check_value({label, ".src1"}, v.src1, issue_o.src1);
    check_value({label, ".src2"}, v.src2, issue_o.src2);
    check_value({label, ".store_data"}, v.store_data, issue_o.store_data);
    check_value({label, ".next_pc"}, v.next_pc, issue_o.next_pc);
    check_value({label, ".fetch_ready"}, 32'd1, 32'(fetch_ready_o));
  endtask

  // hold exec_ready low for delay cycles, then take the issue
  task automatic complete_issue(input string label, input int delay);
    issue_t snapshot;
    int     k;
    snapshot = issue_o;
    for (k = 0; k < delay; k++) begin
      @(posedge clk);
      @(negedge clk);
      check_value({label, ".held_valid"}, 32'd1, 32'(issue_valid_o));
      check_value({label, ".issue_changed"}, 32'd0, 32'(issue_o !== snapshot));
    end
    @(posedge clk);
    exec_ready_i <= 1'b1;
    @(posedge clk);
    exec_ready_i <= 1'b0;
    @(negedge clk);
    check_value({label, ".valid_after_done"}, 32'd0, 32'(issue_valid_o));
  endtask

  task automatic run_vector(input int idx);
    vector_t v;
    string   label;
    bit      seen;
    int      k;
    int      errors_before;
    v             = vec_mem[idx];
    label         = $sformatf("vec%02h", v.name);
    errors_before = errors;
    @(posedge clk);
    drive_vector(v);
    @(negedge clk);
    expect_read_index(label, v);
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    for (k = 0; k < int'(v.hold); k++) begin
      @(negedge clk);
      check_value({label, ".stalled_valid"}, 32'd0, 32'(issue_valid_o));
      expect_read_index(label, v);
      @(posedge clk);
    end
    ex_fwd_i.pending <= 1'b0;
    ex_fwd_i.ready   <= v.ex_flags[0];
    wait_issue(label, seen);
    if (seen) begin
      check_issue(label, v);
      complete_issue(label, int'(v.delay));
    end
    report_test(label, errors_before);
  endtask

  // second instruction arrives while the first waits on execute
  task automatic run_pair(input int idx_a, input int idx_b);
    vector_t va;
    vector_t vb;
    string   label;
    bit      seen;
    int      errors_before;
    va            = vec_mem[idx_a];
    vb            = vec_mem[idx_b];
    label         = "buffered_pair";
    errors_before = errors;
    @(posedge clk);
    drive_vector(va);
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    wait_issue(label, seen);
    if (seen) begin
      check_issue({label, ".first"}, va);
      @(posedge clk);
      drive_vector(vb);
      @(posedge clk);
      fetch_valid_i <= 1'b0;
      @(negedge clk);
      check_value({label, ".buffer_full"}, 32'd0, 32'(fetch_ready_o));
      check_value({label, ".first_held"}, va.pc, issue_o.fetch.pc);
      @(posedge clk);
      exec_ready_i <= 1'b1;
      @(posedge clk);
      exec_ready_i <= 1'b0;
      @(negedge clk);
      check_value({label, ".gap"}, 32'd0, 32'(issue_valid_o));
      wait_issue(label, seen);
      if (seen) begin
        check_issue({label, ".second"}, vb);
        complete_issue(label, 0);
      end
    end
    report_test(label, errors_before);
  endtask

  initial begin
    int errors_before;
    int i;
    clk           = 1'b0;
    rst           = 1'b1;
    fetch_i       = '0;
    fetch_valid_i = 1'b0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    ex_fwd_i      = '0;
    wb_fwd_i      = '0;
    exec_ready_i  = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    $readmemh("testbench/decode_vectors.hex", vec_mem);

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    errors_before = errors;
    check_value("reset.issue_valid", 32'd0, 32'(issue_valid_o));
    check_value("reset.fetch_ready", 32'd1, 32'(fetch_ready_o));
    check_value("reset.issue_pc", 32'd0, issue_o.fetch.pc);
    report_test("reset", errors_before);

    for (i = 0; i < NUM_VECTORS; i++) begin
      run_vector(i);
    end
    run_pair(0, 1);

    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/decode_pkg.sv
rtl/fetch_buffer.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/decode_stage_top.sv
testbench/tb_decode_stage.sv

//--- testbench/decode_vectors.hex
// name pc inst rs1_data rs2_data ex_flags ex_rd ex_data wb_valid wb_rd wb_data
// hold delay | expected: alu_op imm src1 src2 store_data next_pc
01_00001000_123452B7_AAAA0001_BBBB0002_00_00_00000000_00_00_00000000_00_00_0A_12345000_AAAA0001_12345000_BBBB0002_00001004
02_00002000_FFFFF317_11111111_22222222_00_00_00000000_00_00_00000000_00_00_00_FFFFF000_00002000_FFFFF000_22222222_00002004
03_00003000_FFB10093_00000100_33333333_00_00_00000000_00_00_00000000_00_00_00_FFFFFFFB_00000100_FFFFFFFB_33333333_00003004
04_00003080_40725193_80000000_44444444_00_00_00000000_00_00_00000000_00_00_07_00000407_80000000_00000407_44444444_00003084
05_00003100_409403B3_10101010_20202020_01_08_E0E0E0E0_01_09_0B0B0B0B_00_00_01_00000000_E0E0E0E0_0B0B0B0B_0B0B0B0B_00003104
06_00003200_0005C533_30303030_40404040_01_0B_E1E1E1E1_01_0B_B1B1B1B1_00_00_05_00000000_E1E1E1E1_40404040_40404040_00003204
07_00003300_00000633_00000007_00000009_01_00_0000DEAD_01_00_0000BEEF_00_00_00_00000000_00000007_00000009_00000009_00003304
08_00003400_00872683_00000111_00000222_01_0E_00004000_00_00_00000000_03_00_00_00000008_00004000_00000008_00000222_00003404
09_00003500_FEF82E23_00006000_00000333_01_0F_5A5A5A5A_00_00_00000000_02_03_00_FFFFFFFC_00006000_FFFFFFFC_5A5A5A5A_00003504
0A_00004000_FF9FF0EF_00000000_00000444_00_00_00000000_00_00_00000000_00_02_00_FFFFFFF8_00004000_FFFFFFF8_00000444_00003FF8
0B_00004100_005A0067_00008002_00000555_00_00_00000000_00_00_00000000_00_00_00_00000005_00008002_00000005_00000555_00008006
0C_00005000_02208063_0000ABCD_0000ABCD_00_00_00000000_00_00_00000000_00_00_01_00000020_0000ABCD_0000ABCD_0000ABCD_00005020
0D_00005000_FE2088E3_00000001_00000002_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_00000001_00000002_00000002_00005004
0E_00005000_FE2098E3_00000001_00000002_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_00000001_00000002_00000002_00004FF0
0F_00005000_02209063_77777777_77777777_00_00_00000000_00_00_00000000_00_00_01_00000020_77777777_77777777_77777777_00005004
10_00005000_0220C063_FFFFFFFF_00000001_00_00_00000000_00_00_00000000_00_00_01_00000020_FFFFFFFF_00000001_00000001_00005020
11_00005000_0220C063_00000005_FFFFFFFF_00_00_00000000_00_00_00000000_00_00_01_00000020_00000005_FFFFFFFF_FFFFFFFF_00005004
12_00005000_FE20D8E3_00000003_00000003_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_00000003_00000003_00000003_00004FF0
13_00005000_FE20D8E3_80000000_00000000_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_80000000_00000000_00000000_00005004
14_00005000_FE20E8E3_00000001_80000000_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_00000001_80000000_80000000_00004FF0
15_00005000_0220E063_FFFFFFFF_00000001_00_00_00000000_00_00_00000000_00_00_01_00000020_FFFFFFFF_00000001_00000001_00005004
16_00005000_FE20F8E3_80000000_00000001_00_00_00000000_00_00_00000000_00_00_01_FFFFFFF0_80000000_00000001_00000001_00004FF0
17_00005000_0220F063_00000001_00000002_00_00_00000000_00_00_00000000_00_00_01_00000020_00000001_00000002_00000002_00005004
